//--- rtl/amo_params.svh
`ifndef AMO_PARAMS_SVH
`define AMO_PARAMS_SVH

// Word-addressed memory, one full word per access
`define AMO_ADDR_W    6
`define AMO_DATA_W    32
`define AMO_MEM_DEPTH 64

// Store write pipeline depth in cycles
`define AMO_ST_LAT    3

// Outstanding-store count, wide enough for AMO_ST_LAT in flight
`define AMO_CNT_W     3

`endif

//--- rtl/amo_pkg.sv
`include "amo_params.svh"

package amo_pkg;

  // Atomic opcodes, RISC-V AMO set without LR/SC
  typedef enum logic [3:0] {
    AMO_SWAP = 4'h0,
    AMO_ADD  = 4'h1,
    AMO_AND  = 4'h2,
    AMO_OR   = 4'h3,
    AMO_XOR  = 4'h4,
    AMO_MAX  = 4'h5,  // Signed
    AMO_MIN  = 4'h6,  // Signed
    AMO_MAXU = 4'h7,  // Unsigned
    AMO_MINU = 4'h8   // Unsigned
  } amo_op_e;

  // Cache-side controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,  // Memory read lands here
    ST_WRITE = 2'd2   // ALU result written, ack raised
  } amo_state_e;

  // Operation held in the buffer
  typedef struct packed {
    amo_op_e                  op;
    logic [`AMO_ADDR_W-1:0]   addr;     // Word address
    logic [`AMO_DATA_W-1:0]   operand;  // rs2 value
  } amo_entry_t;

  // Buffer to controller
  typedef struct packed {
    logic                     req;      // Held until ack
    amo_op_e                  op;
    logic [`AMO_ADDR_W-1:0]   addr;
    logic [`AMO_DATA_W-1:0]   operand;
  } amo_req_t;

  // Controller back to buffer and out of the subsystem
  typedef struct packed {
    logic                     ack;      // One-cycle strobe
    logic [`AMO_DATA_W-1:0]   rdata;    // Old memory value
  } amo_resp_t;

endpackage

//--- rtl/amo_buffer.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_buffer
  import amo_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       flush_i,          // Pipeline flush strobe
  input  logic       valid_i,          // Issue side has an AMO
  output logic       ready_o,          // Buffer empty
  input  amo_entry_t entry_i,
  input  logic       commit_i,         // Buffered AMO sits at commit
  input  logic       no_st_pending_i,  // Store pipeline fully drained
  output amo_req_t   req_o,            // Towards the controller
  input  logic       ack_i             // Pop strobe from the controller
);

  amo_entry_t entry_q;  // Held operation
  logic       valid_q;  // Entry present
  logic       accept;
  logic       flush_buf;

  assign ready_o = ~valid_q;
  assign accept  = valid_i & ready_o;

  // Once at commit the AMO is no longer speculative so a flush must not drop it
  assign flush_buf = flush_i & ~commit_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (ack_i || flush_buf) begin
      valid_q <= 1'b0;              // Done or squashed
    end else if (accept) begin
      valid_q <= 1'b1;
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_q <= entry_i;
    end
  end

  // Release only when committing and no older store is still in flight
  assign req_o.req     = valid_q & commit_i & no_st_pending_i;
  assign req_o.op      = entry_q.op;
  assign req_o.addr    = entry_q.addr;
  assign req_o.operand = entry_q.operand;

endmodule

//--- rtl/store_drain_counter.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module store_drain_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic st_issue_i,      // Store strobed into the write pipeline
  input  logic st_done_i,       // Store written to memory
  output logic no_st_pending_o  // Count is zero
);

  logic [`AMO_CNT_W-1:0] cnt_q;  // Stores in flight

  // Issue and completion in one cycle cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      case ({st_issue_i, st_done_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;       // Idle or both
      endcase
    end
  end

  // Zero detect gates AMO release
  assign no_st_pending_o = (cnt_q == '0);

endmodule

//--- rtl/amo_ctrl_fsm.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_ctrl_fsm
  import amo_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  amo_req_t               req_i,          // From the buffer
  // Memory port
  output logic [`AMO_ADDR_W-1:0] mem_addr_o,
  output logic                   mem_we_o,
  output logic [`AMO_DATA_W-1:0] mem_wdata_o,
  input  logic [`AMO_DATA_W-1:0] mem_rdata_i,    // Registered read data
  // ALU port
  output amo_op_e                alu_op_o,
  output logic [`AMO_DATA_W-1:0] alu_old_o,
  output logic [`AMO_DATA_W-1:0] alu_operand_o,
  input  logic [`AMO_DATA_W-1:0] alu_result_i,
  // Response
  output amo_resp_t              resp_o
);

  amo_state_e             state_q;
  amo_state_e             state_d;
  logic [`AMO_DATA_W-1:0] old_q;    // Memory value before the update

  // IDLE -> READ -> WRITE -> IDLE, only IDLE waits
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_i.req) begin
          state_d = ST_READ;       // Address already on the port
        end
      end
      ST_READ:  state_d = ST_WRITE;
      ST_WRITE: state_d = ST_IDLE;  // Buffer pops on this ack
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Registered read data is valid in READ
  always_ff @(posedge clk_i) begin
    if (state_q == ST_READ) begin
      old_q <= mem_rdata_i;
    end
  end

  // Request address is stable until ack
  assign mem_addr_o = req_i.addr;

  // ALU sees the captured word and the request operand
  assign alu_op_o      = req_i.op;
  assign alu_old_o     = old_q;
  assign alu_operand_o = req_i.operand;

  // Write-back and ack share the WRITE cycle
  assign mem_we_o     = (state_q == ST_WRITE);
  assign mem_wdata_o  = alu_result_i;
  assign resp_o.ack   = (state_q == ST_WRITE);
  assign resp_o.rdata = old_q;          // AMO returns the old value

endmodule

//--- rtl/amo_alu.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_alu
  import amo_pkg::*;
(
  input  amo_op_e                op_i,
  input  logic [`AMO_DATA_W-1:0] old_i,      // Current memory word
  input  logic [`AMO_DATA_W-1:0] operand_i,  // rs2 value
  output logic [`AMO_DATA_W-1:0] result_o    // Word to write back
);

  logic old_lt_s;  // old < operand, two's complement
  logic old_lt_u;  // old < operand, unsigned

  assign old_lt_s = $signed(old_i) < $signed(operand_i);
  assign old_lt_u = old_i < operand_i;

  always_comb begin
    unique case (op_i)
      AMO_SWAP: result_o = operand_i;
      AMO_ADD:  result_o = old_i + operand_i;  // Wraps
      AMO_AND:  result_o = old_i & operand_i;
      AMO_OR:   result_o = old_i | operand_i;
      AMO_XOR:  result_o = old_i ^ operand_i;
      AMO_MAX:  result_o = old_lt_s ? operand_i : old_i;
      AMO_MIN:  result_o = old_lt_s ? old_i : operand_i;
      AMO_MAXU: result_o = old_lt_u ? operand_i : old_i;
      AMO_MINU: result_o = old_lt_u ? old_i : operand_i;
      // Unused encodings leave memory untouched
      default:  result_o = old_i;
    endcase
  end

endmodule

//--- rtl/amo_mem.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_mem (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // AMO port, read registered
  input  logic [`AMO_ADDR_W-1:0] amo_addr_i,
  input  logic                   amo_we_i,
  input  logic [`AMO_DATA_W-1:0] amo_wdata_i,
  output logic [`AMO_DATA_W-1:0] amo_rdata_o,
  // Store port, no back-pressure
  input  logic                   st_valid_i,
  input  logic [`AMO_ADDR_W-1:0] st_addr_i,
  input  logic [`AMO_DATA_W-1:0] st_data_i,
  output logic                   st_done_o   // Pulses when a store lands
);

  typedef struct packed {
    logic [`AMO_ADDR_W-1:0] addr;
    logic [`AMO_DATA_W-1:0] data;
  } st_stage_t;

  logic [`AMO_DATA_W-1:0] mem_q [`AMO_MEM_DEPTH];
  logic [`AMO_ST_LAT-1:0] st_vld_q;               // Stage valids
  st_stage_t              st_pipe_q [`AMO_ST_LAT]; // Stage payloads

  // Delay line, one stage per cycle of store latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      st_vld_q <= '0;
    end else begin
      st_vld_q <= {st_vld_q[`AMO_ST_LAT-2:0], st_valid_i};
    end
  end

  always_ff @(posedge clk_i) begin
    st_pipe_q[0] <= '{addr: st_addr_i, data: st_data_i};
    for (int i = 1; i < `AMO_ST_LAT; i++) begin
      st_pipe_q[i] <= st_pipe_q[i-1];
    end
  end

  assign st_done_o = st_vld_q[`AMO_ST_LAT-1];

  // Store first then AMO so the AMO wins a same-address collision
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `AMO_MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (st_done_o) mem_q[st_pipe_q[`AMO_ST_LAT-1].addr] <= st_pipe_q[`AMO_ST_LAT-1].data;
      if (amo_we_i)  mem_q[amo_addr_i] <= amo_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    amo_rdata_o <= mem_q[amo_addr_i];  // Old value, one cycle after address
  end

endmodule

//--- rtl/amo_subsys_top.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_subsys_top
  import amo_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   flush_i,
  // Issue and commit side
  input  logic                   valid_i,
  output logic                   ready_o,
  input  amo_entry_t             entry_i,
  input  logic                   commit_i,
  // Plain stores
  input  logic                   st_valid_i,
  input  logic [`AMO_ADDR_W-1:0] st_addr_i,
  input  logic [`AMO_DATA_W-1:0] st_data_i,
  // Old value out
  output logic                   result_valid_o,
  output logic [`AMO_DATA_W-1:0] result_o
);

  amo_req_t               req;
  amo_resp_t              resp;
  logic                   no_st_pending;
  logic                   st_done;
  logic [`AMO_ADDR_W-1:0] mem_addr;
  logic                   mem_we;
  logic [`AMO_DATA_W-1:0] mem_wdata;
  logic [`AMO_DATA_W-1:0] mem_rdata;
  amo_op_e                alu_op;
  logic [`AMO_DATA_W-1:0] alu_old;
  logic [`AMO_DATA_W-1:0] alu_operand;
  logic [`AMO_DATA_W-1:0] alu_result;

  amo_buffer amo_buffer_inst (
    .clk_i, .reset_i, .flush_i, .valid_i, .ready_o, .entry_i, .commit_i,
    .no_st_pending_i (no_st_pending),
    .req_o           (req),
    .ack_i           (resp.ack)
  );

  store_drain_counter store_drain_counter_inst (
    .clk_i, .reset_i,
    .st_issue_i      (st_valid_i),
    .st_done_i       (st_done),
    .no_st_pending_o (no_st_pending)
  );

  amo_ctrl_fsm amo_ctrl_fsm_inst (
    .clk_i, .reset_i,
    .req_i (req),
    .mem_addr_o (mem_addr), .mem_we_o (mem_we), .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .alu_op_o (alu_op), .alu_old_o (alu_old), .alu_operand_o (alu_operand),
    .alu_result_i (alu_result),
    .resp_o (resp)
  );

  amo_alu amo_alu_inst (
    .op_i (alu_op), .old_i (alu_old), .operand_i (alu_operand), .result_o (alu_result)
  );

  amo_mem amo_mem_inst (
    .clk_i, .reset_i,
    .amo_addr_i (mem_addr), .amo_we_i (mem_we), .amo_wdata_i (mem_wdata),
    .amo_rdata_o (mem_rdata),
    .st_valid_i, .st_addr_i, .st_data_i,
    .st_done_o (st_done)
  );

  assign result_valid_o = resp.ack;
  assign result_o       = resp.rdata;

endmodule

//--- tb/amo_subsys_props.sv
`timescale 1ns/1ns

module amo_subsys_props (
  input logic clk_i,
  input logic reset_i,
  input logic valid_i,          // Issue side offers an AMO
  input logic flush_i,          // Pipeline flush strobe
  input logic st_valid_i,       // Store strobe into the write pipeline
  input logic req_i,            // Buffer request to the controller
  input logic ack_i,            // Controller ack strobe
  input logic ready_i           // Buffer empty
);

  // Ack is a one-cycle strobe
  ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_i |=> !ack_i)
    else $error("ack high on two consecutive cycles");

  // New request seen in IDLE, READ follows, ack in WRITE
  ack_not_early: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(req_i) |=> !ack_i)
    else $error("ack one cycle after the request");

  ack_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(req_i) |-> ##2 ack_i)
    else $error("ack missing two cycles after the request");

  // A store strobed in the last three cycles has not reached memory yet
  req_after_drain: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> !$past(st_valid_i, 1) && !$past(st_valid_i, 2) && !$past(st_valid_i, 3))
    else $error("request raised with stores still in flight");

  // Accepted entry is held, ready drops on the next cycle
  accept_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_i && ready_i) |=> !ready_i)
    else $error("ready high right after an accepted AMO");

  // Held entry leaves only on ack or flush
  ready_returns: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ready_i) |-> $past(ack_i || flush_i))
    else $error("ready rose without an ack or a flush");

endmodule

//--- tb/amo_subsys_tb.sv
`timescale 1ns/1ns
`include "amo_params.svh"

module amo_subsys_tb
  import amo_pkg::*;
();

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   flush;
  logic                   valid;
  logic                   ready;
  amo_entry_t             entry;
  logic                   commit;
  logic                   st_valid;
  logic [`AMO_ADDR_W-1:0] st_addr;
  logic [`AMO_DATA_W-1:0] st_data;
  logic                   result_valid;
  logic [`AMO_DATA_W-1:0] result;

  logic [`AMO_DATA_W-1:0] model_mem [`AMO_MEM_DEPTH];  // Reference memory
  int                     err_cnt;
  int                     chk_cnt;
  int                     timeout_cnt;

  always #4 clk = ~clk;  // 8 ns period

  amo_subsys_top amo_subsys_top_inst (
    .clk_i (clk), .reset_i (reset), .flush_i (flush),
    .valid_i (valid), .ready_o (ready), .entry_i (entry), .commit_i (commit),
    .st_valid_i (st_valid), .st_addr_i (st_addr), .st_data_i (st_data),
    .result_valid_o (result_valid), .result_o (result)
  );

  // Handshake checks sit inside the top level
  bind amo_subsys_top amo_subsys_props amo_subsys_props_inst (
    .clk_i (clk_i), .reset_i (reset_i), .valid_i (valid_i), .flush_i (flush_i),
    .st_valid_i (st_valid_i), .req_i (req.req), .ack_i (resp.ack), .ready_i (ready_o)
  );

  // RISC-V AMO rule, new memory word from old word and rs2
  function automatic logic [`AMO_DATA_W-1:0] amo_model(amo_op_e op,
      logic [`AMO_DATA_W-1:0] mem_val, logic [`AMO_DATA_W-1:0] rs2);
    logic [`AMO_DATA_W-1:0] res;
    case (op)
      AMO_SWAP: res = rs2;
      AMO_ADD:  res = mem_val + rs2;
      AMO_AND:  res = mem_val & rs2;
      AMO_OR:   res = mem_val | rs2;
      AMO_XOR:  res = mem_val ^ rs2;
      AMO_MAX:  res = ($signed(mem_val) > $signed(rs2)) ? mem_val : rs2;
      AMO_MIN:  res = ($signed(mem_val) < $signed(rs2)) ? mem_val : rs2;
      AMO_MAXU: res = (mem_val > rs2) ? mem_val : rs2;
      AMO_MINU: res = (mem_val < rs2) ? mem_val : rs2;
      default:  res = mem_val;
    endcase
    return res;
  endfunction

  function automatic logic [`AMO_ADDR_W-1:0] rand_addr();
    int r;
    r = $urandom_range(0, 15);  // Small window so words get reused
    return r[`AMO_ADDR_W-1:0];
  endfunction

  function automatic amo_op_e rand_op();
    int r;
    r = $urandom_range(0, 8);
    return amo_op_e'(r[3:0]);
  endfunction

  task automatic log_error(string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  // Inputs change 1 ns after the edge, outputs read there too
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_for_ready();
    int n;
    n = 0;
    while (!ready && n < 200) begin
      next_cycle();
      n++;
    end
    if (!ready) begin
      $display("Timeout at %0t ns: ready_o stayed low for 200 cycles", $time);
      timeout_cnt++;
    end
  endtask

  task automatic issue_store(logic [`AMO_ADDR_W-1:0] addr, logic [`AMO_DATA_W-1:0] data);
    st_valid = 1'b1;
    st_addr  = addr;
    st_data  = data;
    model_mem[addr] = data;  // Program order, AMO waits for the drain
    next_cycle();
    st_valid = 1'b0;
  endtask

  // Returns one cycle after acceptance
  task automatic issue_amo(amo_op_e op, logic [`AMO_ADDR_W-1:0] addr,
      logic [`AMO_DATA_W-1:0] operand, logic at_commit);
    wait_for_ready();
    valid         = 1'b1;
    entry.op      = op;
    entry.addr    = addr;
    entry.operand = operand;
    commit        = at_commit;
    next_cycle();
    valid = 1'b0;
  endtask

  // Old value check, ready low until ack and high right after
  task automatic await_result(amo_op_e op, logic [`AMO_ADDR_W-1:0] addr,
      logic [`AMO_DATA_W-1:0] operand);
    logic [`AMO_DATA_W-1:0] exp_old;
    int n;
    exp_old = model_mem[addr];
    n = 0;
    while (!result_valid && n < 200) begin
      chk_cnt++;
      if (ready) log_error("ready_o high while the AMO is still held");
      next_cycle();
      n++;
    end
    if (!result_valid) begin
      $display("Timeout at %0t ns: no result_valid_o within 200 cycles", $time);
      timeout_cnt++;
    end else begin
      chk_cnt++;
      if (result != exp_old) begin
        log_error($sformatf("%s addr %0d returned %h, expected %h",
                            op.name(), addr, result, exp_old));
      end
      if (ready) log_error("ready_o high in the ack cycle");
      model_mem[addr] = amo_model(op, exp_old, operand);
      next_cycle();
      if (!ready) log_error("ready_o low on the cycle after ack");
    end
    commit = 1'b0;
  endtask

  task automatic run_amo(amo_op_e op, logic [`AMO_ADDR_W-1:0] addr,
      logic [`AMO_DATA_W-1:0] operand);
    issue_amo(op, addr, operand, 1'b1);
    await_result(op, addr, operand);
  endtask

  // Old word and operand on opposite sides of the sign bit, both orders
  task automatic minmax_pair(amo_op_e op);
    logic [`AMO_ADDR_W-1:0] addr;
    logic [`AMO_DATA_W-1:0] neg;
    logic [`AMO_DATA_W-1:0] pos;
    addr = rand_addr();
    neg  = $urandom() | 32'h8000_0000;
    pos  = $urandom() & 32'h7fff_ffff;
    run_amo(AMO_SWAP, addr, neg);
    run_amo(op, addr, pos);
    run_amo(AMO_SWAP, addr, pos);
    run_amo(op, addr, neg);
    run_amo(AMO_OR, addr, '0);  // Read back
  endtask

  initial begin
    logic [`AMO_ADDR_W-1:0] addr;
    logic [`AMO_DATA_W-1:0] operand;
    int                     n_st;
    void'($urandom(47318));  // Seed once
    reset       = 1'b1;
    flush       = 1'b0;
    valid       = 1'b0;
    entry       = '0;
    commit      = 1'b0;
    st_valid    = 1'b0;
    st_addr     = '0;
    st_data     = '0;
    err_cnt     = 0;
    chk_cnt     = 0;
    timeout_cnt = 0;
    for (int i = 0; i < `AMO_MEM_DEPTH; i++) model_mem[i] = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    chk_cnt++;
    if (!ready || result_valid) log_error("ready_o or result_valid_o wrong after reset");

    // Random AMOs over all opcodes, committed at once
    for (int i = 0; i < 60; i++) run_amo(rand_op(), rand_addr(), $urandom());

    // Stores right in front of an AMO to the same word
    for (int i = 0; i < 12; i++) begin
      addr = rand_addr();
      n_st = $urandom_range(1, 3);
      for (int k = 0; k < n_st; k++) issue_store(addr, $urandom());
      run_amo(rand_op(), addr, $urandom());
    end

    // Speculative AMO squashed before commit
    addr = rand_addr();
    issue_amo(AMO_SWAP, addr, $urandom(), 1'b0);
    chk_cnt++;
    if (ready) log_error("speculative AMO was not accepted");
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    if (!ready) log_error("ready_o not back high after the flush");
    for (int i = 0; i < 20; i++) begin
      if (result_valid) log_error("result_valid_o from a flushed AMO");
      next_cycle();
    end
    run_amo(AMO_OR, addr, '0);  // Word must be untouched

    // Flush in the same cycle that commit rises, AMO survives
    addr    = rand_addr();
    operand = $urandom();
    issue_amo(AMO_ADD, addr, operand, 1'b0);
    commit = 1'b1;
    flush  = 1'b1;
    next_cycle();
    flush = 1'b0;
    await_result(AMO_ADD, addr, operand);

    // Signed and unsigned compares
    for (int i = 0; i < 3; i++) begin
      minmax_pair(AMO_MAX);
      minmax_pair(AMO_MIN);
      minmax_pair(AMO_MAXU);
      minmax_pair(AMO_MINU);
    end

    next_cycle();
    $display("Checks: %0d  errors: %0d  timeouts: %0d", chk_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/amo_pkg.sv
rtl/amo_buffer.sv
rtl/store_drain_counter.sv
rtl/amo_ctrl_fsm.sv
rtl/amo_alu.sv
rtl/amo_mem.sv
rtl/amo_subsys_top.sv
tb/amo_subsys_props.sv
tb/amo_subsys_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' flist.f)

all: run

obj_dir/Vamo_subsys_tb: flist.f $(SRCS) rtl/amo_params.svh
	verilator --binary --timing --assert -f flist.f --top-module amo_subsys_tb

run: obj_dir/Vamo_subsys_tb
	./obj_dir/Vamo_subsys_tb > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
